//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// integer register and data path width
`define RV_XLEN 32

// program counter width
`define RV_PC_WIDTH 32

// register file geometry
`define RV_REG_AW 5
`define RV_REG_NUM 32

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

  // base opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'b00,
    ALU_SUB    = 2'b01,
    ALU_FUNCT  = 2'b10, // execute looks at funct3/funct7
    ALU_BRANCH = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    SRCA_RS1  = 2'b00,
    SRCA_PC   = 2'b01,
    SRCA_ZERO = 2'b10
  } src_a_e;

  typedef enum logic [1:0] {
    SRCB_RS2  = 2'b00,
    SRCB_IMM  = 2'b01,
    SRCB_FOUR = 2'b10
  } src_b_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'b00,
    WB_MEM = 2'b01,
    WB_PC4 = 2'b10,
    WB_CSR = 2'b11
  } wb_sel_e;

  // branch funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct_e;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] waddr,
  input  logic [`RV_XLEN-1:0]   wdata,
  input  logic [`RV_REG_AW-1:0] raddr1,
  output logic [`RV_XLEN-1:0]   rdata1,
  input  logic [`RV_REG_AW-1:0] raddr2,
  output logic [`RV_XLEN-1:0]   rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

  // single write port, x0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // async reads, no bypass of the write in flight
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module imm_gen import rv_pkg::*; (
  input  logic [31:0]         inst,
  output logic [`RV_XLEN-1:0] imm
);

  localparam int XW = `RV_XLEN;

  opcode_e opcode;

  assign opcode = opcode_e'(inst[6:0]);

  // each field is built as a signed value, the size cast sign-extends it
  always_comb begin
    unique case (opcode)
      OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM: begin
        imm = XW'($signed(inst[31:20])); // I-type
      end
      OP_STORE: begin
        imm = XW'($signed({inst[31:25], inst[11:7]})); // S-type
      end
      OP_BRANCH: begin
        // B-type, bit 0 always zero
        imm = XW'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
      end
      OP_LUI, OP_AUIPC: begin
        imm = XW'($signed({inst[31:12], 12'b0})); // upper 20 bits
      end
      OP_JAL: begin
        // J-type, 21 bit offset
        imm = XW'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- hdl/main_control.sv
`timescale 1ns/1ns

module main_control import rv_pkg::*; (
  input  opcode_e opcode,
  output alu_op_e alu_op,
  output src_a_e  src_a,
  output src_b_e  src_b,
  output wb_sel_e wb_sel,
  output logic    reg_write,
  output logic    mem_write,
  output logic    mem_read,
  output logic    csr_we,
  output logic    branch,
  output logic    jump,
  output logic    jalr_src,
  output logic    utype_src,
  output logic    jtype_src
);

  always_comb begin
    // everything inactive unless the opcode says otherwise
    alu_op    = ALU_ADD;
    src_a     = SRCA_RS1;
    src_b     = SRCB_RS2;
    wb_sel    = WB_ALU;
    reg_write = 1'b0;
    mem_write = 1'b0;
    mem_read  = 1'b0;
    csr_we    = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    jalr_src  = 1'b0;
    utype_src = 1'b0;
    jtype_src = 1'b0;

    case (opcode)
      OP_LUI: begin
        src_a     = SRCA_ZERO; // 0 + imm
        src_b     = SRCB_IMM;
        reg_write = 1'b1;
      end
      OP_AUIPC: begin
        src_a     = SRCA_PC;
        src_b     = SRCB_IMM;
        utype_src = 1'b1;
        reg_write = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        // link value is pc + 4
        src_a     = SRCA_PC;
        src_b     = SRCB_FOUR;
        wb_sel    = WB_PC4;
        jump      = 1'b1;
        jtype_src = 1'b1;
        jalr_src  = (opcode == OP_JALR);
        reg_write = 1'b1;
      end
      OP_BRANCH: begin
        alu_op = ALU_BRANCH;
        src_b  = SRCB_RS2;
        branch = 1'b1;
      end
      OP_LOAD: begin
        src_b     = SRCB_IMM; // address = rs1 + imm
        mem_read  = 1'b1;
        wb_sel    = WB_MEM;
        reg_write = 1'b1;
      end
      OP_STORE: begin
        src_b     = SRCB_IMM;
        mem_write = 1'b1;
      end
      OP_IMM: begin
        alu_op    = ALU_FUNCT;
        src_b     = SRCB_IMM;
        reg_write = 1'b1;
      end
      OP_REG: begin
        alu_op    = ALU_FUNCT;
        reg_write = 1'b1;
      end
      OP_SYSTEM: begin
        // old csr value goes to rd
        csr_we    = 1'b1;
        wb_sel    = WB_CSR;
        reg_write = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hdl/branch_compare.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module branch_compare import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] rs1,
  input  logic [`RV_XLEN-1:0] rs2,
  input  br_funct_e           funct3,
  output logic                taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1 == rs2);
  assign lt  = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (funct3)
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt;
      BR_BGE:  taken = !lt;
      BR_BLTU: taken = ltu;
      BR_BGEU: taken = !ltu;
      default: taken = 1'b0; // 010, 011 are not branches
    endcase
  end

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
  input  logic clk,
  input  logic arst_n,
  input  logic pc_src,
  output logic id_reg_flush,
  output logic zero_sel
);

  // fetched instruction after the branch is dropped right away
  assign id_reg_flush = pc_src;

  // the one already in IF/ID reaches decode next cycle,
  // its controls get zeroed for that cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      zero_sel <= 1'b0;
    end else begin
      zero_sel <= pc_src;
    end
  end

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module id_stage import rv_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`RV_PC_WIDTH-1:0] pc,
  input  logic [31:0]             inst,
  input  logic [`RV_REG_AW-1:0]   addr_rs1,
  input  logic [`RV_REG_AW-1:0]   addr_rs2,
  input  logic [`RV_REG_AW-1:0]   addr_rd,
  input  logic                    reg_we,
  input  logic [`RV_XLEN-1:0]     data_rd,

  output logic [`RV_XLEN-1:0]     data_rs1,
  output logic [`RV_XLEN-1:0]     data_rs2,
  output logic [`RV_XLEN-1:0]     data_utype_rs1,
  output logic [`RV_XLEN-1:0]     data_imm,
  output logic [`RV_PC_WIDTH-1:0] branch_pc_new,

  output alu_op_e                 ctrl_alu_op,
  output logic                    ctrl_pc_src,
  output logic                    ctrl_reg_we,
  output src_a_e                  ctrl_alu_src_a,
  output src_b_e                  ctrl_alu_src_b,
  output logic                    ctrl_mem_write,
  output logic                    ctrl_mem_read,
  output wb_sel_e                 ctrl_mem_to_reg,
  output logic                    ctrl_id_reg_flush,
  output logic                    ctrl_csr_we,

  output logic [11:0]             csr_addr,
  output logic [2:0]              csr_func
);

  localparam int XW = `RV_XLEN;

  logic [`RV_XLEN-1:0]     imm;
  logic [`RV_PC_WIDTH-1:0] target_base;

  // raw controls before zeroing
  alu_op_e alu_op;
  src_a_e  src_a;
  src_b_e  src_b;
  wb_sel_e wb_sel;
  logic    reg_write;
  logic    mem_write;
  logic    mem_read;
  logic    csr_we;
  logic    branch;
  logic    jump;
  logic    jalr_src;
  logic    utype_src;
  logic    jtype_src;

  logic    taken;
  logic    zero_sel;

  reg_file reg_file_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (reg_we),
    .waddr  (addr_rd),
    .wdata  (data_rd),
    .raddr1 (addr_rs1),
    .rdata1 (data_rs1),
    .raddr2 (addr_rs2),
    .rdata2 (data_rs2)
  );

  imm_gen imm_gen_inst (
    .inst (inst),
    .imm  (imm)
  );

  main_control main_control_inst (
    .opcode    (opcode_e'(inst[6:0])),
    .alu_op    (alu_op),
    .src_a     (src_a),
    .src_b     (src_b),
    .wb_sel    (wb_sel),
    .reg_write (reg_write),
    .mem_write (mem_write),
    .mem_read  (mem_read),
    .csr_we    (csr_we),
    .branch    (branch),
    .jump      (jump),
    .jalr_src  (jalr_src),
    .utype_src (utype_src),
    .jtype_src (jtype_src)
  );

  branch_compare branch_compare_inst (
    .rs1    (data_rs1),
    .rs2    (data_rs2),
    .funct3 (br_funct_e'(inst[14:12])),
    .taken  (taken)
  );

  hazard_unit hazard_unit_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .pc_src       (ctrl_pc_src),
    .id_reg_flush (ctrl_id_reg_flush),
    .zero_sel     (zero_sel)
  );

  // redirect resolved here, one bubble instead of two
  assign ctrl_pc_src = jump || (branch && taken);

  // jalr is register relative, jal and branches pc relative
  assign target_base   = jalr_src ? data_rs1 : pc;
  assign branch_pc_new = target_base + imm;

  assign data_utype_rs1 = utype_src ? pc : '0; // auipc adds to pc
  assign data_imm       = jtype_src ? XW'(4) : imm; // link offset for jumps

  // wrong-path instruction turns into a bubble
  assign ctrl_alu_op     = zero_sel ? ALU_ADD  : alu_op;
  assign ctrl_alu_src_a  = zero_sel ? SRCA_RS1 : src_a;
  assign ctrl_alu_src_b  = zero_sel ? SRCB_RS2 : src_b;
  assign ctrl_mem_to_reg = zero_sel ? WB_ALU   : wb_sel;
  assign ctrl_reg_we     = zero_sel ? 1'b0     : reg_write;
  assign ctrl_mem_write  = zero_sel ? 1'b0     : mem_write;
  assign ctrl_mem_read   = zero_sel ? 1'b0     : mem_read;
  assign ctrl_csr_we     = zero_sel ? 1'b0     : csr_we;

  assign csr_addr = inst[31:20];
  assign csr_func = inst[14:12];

endmodule

//--- dv/tb_id_stage.sv
`timescale 1ns/1ns

`include "rv_defines.svh"

module tb_id_stage import rv_pkg::*; ();

  // expected control bundles {alu_op, src_a, src_b, wb_sel, reg_we, mem_w, mem_r, csr_we}
  localparam logic [11:0] C_NONE  = 12'h000;
  localparam logic [11:0] C_ALU   = {ALU_FUNCT, SRCA_RS1, SRCB_RS2, WB_ALU, 4'b1000};
  localparam logic [11:0] C_ALU_I = {ALU_FUNCT, SRCA_RS1, SRCB_IMM, WB_ALU, 4'b1000};
  localparam logic [11:0] C_LOAD  = {ALU_ADD, SRCA_RS1, SRCB_IMM, WB_MEM, 4'b1010};
  localparam logic [11:0] C_STORE = {ALU_ADD, SRCA_RS1, SRCB_IMM, WB_ALU, 4'b0100};
  localparam logic [11:0] C_LUI   = {ALU_ADD, SRCA_ZERO, SRCB_IMM, WB_ALU, 4'b1000};
  localparam logic [11:0] C_AUIPC = {ALU_ADD, SRCA_PC, SRCB_IMM, WB_ALU, 4'b1000};
  localparam logic [11:0] C_JUMP  = {ALU_ADD, SRCA_PC, SRCB_FOUR, WB_PC4, 4'b1000};
  localparam logic [11:0] C_BR    = {ALU_BRANCH, SRCA_RS1, SRCB_RS2, WB_ALU, 4'b0000};
  localparam logic [11:0] C_CSR   = {ALU_ADD, SRCA_RS1, SRCB_RS2, WB_CSR, 4'b1001};

  localparam logic [31:0] I_ADD = 32'h0020_81B3; // add x3, x1, x2
  localparam logic [31:0] I_SW  = 32'hFE20_AA23; // sw x2, -12(x1)
  localparam logic [31:0] I_JAL = 32'hFF1F_F0EF; // jal x1, -16
  localparam logic [31:0] I_BEQ = 32'hFE20_80E3; // beq x1, x2, -32

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        load; // preload x1 and x2 first
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] utype;
    logic [31:0] target;
    logic [11:0] ctrl;
    logic        redirect;
  } entry_t;

  logic                    clk;
  logic                    arst_n;
  logic [`RV_PC_WIDTH-1:0] pc;
  logic [31:0]             inst;
  logic [`RV_REG_AW-1:0]   addr_rs1;
  logic [`RV_REG_AW-1:0]   addr_rs2;
  logic [`RV_REG_AW-1:0]   addr_rd;
  logic                    reg_we;
  logic [`RV_XLEN-1:0]     data_rd;
  logic [`RV_XLEN-1:0]     data_rs1;
  logic [`RV_XLEN-1:0]     data_rs2;
  logic [`RV_XLEN-1:0]     data_utype_rs1;
  logic [`RV_XLEN-1:0]     data_imm;
  logic [`RV_PC_WIDTH-1:0] branch_pc_new;
  alu_op_e                 ctrl_alu_op;
  logic                    ctrl_pc_src;
  logic                    ctrl_reg_we;
  src_a_e                  ctrl_alu_src_a;
  src_b_e                  ctrl_alu_src_b;
  logic                    ctrl_mem_write;
  logic                    ctrl_mem_read;
  wb_sel_e                 ctrl_mem_to_reg;
  logic                    ctrl_id_reg_flush;
  logic                    ctrl_csr_we;
  logic [11:0]             csr_addr;
  logic [2:0]              csr_func;

  logic [31:0] shadow [`RV_REG_NUM]; // what the register file should hold
  entry_t      tbl [$];
  integer      seed;
  int          errors = 0;
  int          checks = 0;

  id_stage id_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin : watchdog
    int n;
    for (n = 0; n < 2000; n++) begin
      @(posedge clk);
    end
    $display("timeout, the run did not finish within %0d clock cycles", n);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_ctrl(input logic [11:0] c, input logic redirect);
    check("ctrl_alu_op", 32'(c[11:10]), 32'(ctrl_alu_op));
    check("ctrl_alu_src_a", 32'(c[9:8]), 32'(ctrl_alu_src_a));
    check("ctrl_alu_src_b", 32'(c[7:6]), 32'(ctrl_alu_src_b));
    check("ctrl_mem_to_reg", 32'(c[5:4]), 32'(ctrl_mem_to_reg));
    check("ctrl_reg_we", 32'(c[3]), 32'(ctrl_reg_we));
    check("ctrl_mem_write", 32'(c[2]), 32'(ctrl_mem_write));
    check("ctrl_mem_read", 32'(c[1]), 32'(ctrl_mem_read));
    check("ctrl_csr_we", 32'(c[0]), 32'(ctrl_csr_we));
    check("ctrl_pc_src", 32'(redirect), 32'(ctrl_pc_src));
    check("ctrl_id_reg_flush", 32'(redirect), 32'(ctrl_id_reg_flush));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2; // inputs change just after the edge
  endtask

  // register addresses follow the instruction fields
  task automatic drive_inst(input logic [31:0] i, input logic [31:0] p);
    inst     = i;
    pc       = p;
    addr_rs1 = i[19:15];
    addr_rs2 = i[24:20];
    addr_rd  = i[11:7];
    reg_we   = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] a, input logic [31:0] v);
    drive_inst(32'h0, 32'h0);
    addr_rs1 = a;
    addr_rd  = a;
    reg_we   = 1'b1;
    data_rd  = v;
    #10;
    check("data_rs1 in write cycle", shadow[a], data_rs1); // old value, no bypass
    next_cycle();
    reg_we = 1'b0;
    if (a != 5'd0)
      shadow[a] = v;
  endtask

  // six conditions share pc 0x400 and offset -32
  task automatic add_branch(input br_funct_e f3, input logic [31:0] a, input logic [31:0] b,
                            input logic taken);
    tbl.push_back(entry_t'{I_BEQ | (32'(f3) << 12), 32'h400, 1'b1, a, b,
                           32'hFFFF_FFE0, 32'h0, 32'h0000_03E0, C_BR, taken});
  endtask

  task automatic apply_entry(input entry_t e);
    if (e.load) begin
      write_reg(5'd1, e.a);
      write_reg(5'd2, e.b);
    end
    drive_inst(e.inst, e.pc);
    #10;
    check("data_rs1", shadow[addr_rs1], data_rs1);
    check("data_rs2", shadow[addr_rs2], data_rs2);
    check("data_imm", e.imm, data_imm);
    check("data_utype_rs1", e.utype, data_utype_rs1);
    check("branch_pc_new", e.target, branch_pc_new);
    check("csr_addr", 32'(e.inst[31:20]), 32'(csr_addr));
    check("csr_func", 32'(e.inst[14:12]), 32'(csr_func));
    check_ctrl(e.ctrl, e.redirect);
    next_cycle();
    drive_inst(32'h0, 32'h0); // bubble soaks up any zeroing
    next_cycle();
  endtask

  // victim is the wrong-path instruction decoded right after the redirect
  task automatic redirect_then_check(input logic [31:0] redir, input logic [31:0] victim,
                                     input logic [11:0] c);
    drive_inst(redir, 32'h600);
    #10;
    check("ctrl_pc_src on redirect", 32'h1, 32'(ctrl_pc_src));
    next_cycle();
    drive_inst(victim, 32'h604);
    #10;
    check_ctrl(C_NONE, 1'b0);
    next_cycle();
    #10;
    check_ctrl(c, 1'b0); // same instruction, one cycle later
    next_cycle();
  endtask

  initial begin : main
    int          r;
    logic [31:0] v;
    seed    = 32'hd6bd_83fc;
    shadow  = '{default: '0};
    arst_n  = 1'b0;
    data_rd = '0;
    drive_inst(I_JAL, 32'h0); // redirect pending while reset is held
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    drive_inst(I_ADD, 32'h0);
    #10;
    check_ctrl(C_ALU, 1'b0);
    next_cycle();

    for (r = 0; r < `RV_REG_NUM; r++) begin
      v = $random(seed);
      write_reg(r[4:0], v); // x0 included
    end
    for (r = 0; r < `RV_REG_NUM; r++) begin
      addr_rs1 = r[4:0];
      addr_rs2 = 5'(`RV_REG_NUM - 1 - r);
      #10;
      check("data_rs1 readback", shadow[addr_rs1], data_rs1);
      check("data_rs2 readback", shadow[addr_rs2], data_rs2);
      next_cycle();
    end

    tbl.push_back(entry_t'{32'hFFB0_8193, 32'h100, 1'b0, 32'h0, 32'h0,
                           32'hFFFF_FFFB, 32'h0, 32'h0000_00FB, C_ALU_I, 1'b0}); // addi
    tbl.push_back(entry_t'{32'h0080_A183, 32'h104, 1'b0, 32'h0, 32'h0,
                           32'h0000_0008, 32'h0, 32'h0000_010C, C_LOAD, 1'b0}); // lw
    tbl.push_back(entry_t'{I_SW, 32'h108, 1'b0, 32'h0, 32'h0,
                           32'hFFFF_FFF4, 32'h0, 32'h0000_00FC, C_STORE, 1'b0});
    tbl.push_back(entry_t'{I_ADD, 32'h10C, 1'b0, 32'h0, 32'h0,
                           32'h0, 32'h0, 32'h0000_010C, C_ALU, 1'b0});
    tbl.push_back(entry_t'{32'h1234_51B7, 32'h110, 1'b0, 32'h0, 32'h0,
                           32'h1234_5000, 32'h0, 32'h1234_5110, C_LUI, 1'b0}); // lui
    tbl.push_back(entry_t'{32'h8000_0197, 32'h200, 1'b0, 32'h0, 32'h0,
                           32'h8000_0000, 32'h200, 32'h8000_0200, C_AUIPC, 1'b0}); // auipc
    tbl.push_back(entry_t'{I_JAL, 32'h300, 1'b0, 32'h0, 32'h0,
                           32'h4, 32'h0, 32'h0000_02F0, C_JUMP, 1'b1});
    tbl.push_back(entry_t'{32'h0140_82E7, 32'h304, 1'b1, 32'h1000_0100, 32'h0,
                           32'h4, 32'h0, 32'h1000_0114, C_JUMP, 1'b1}); // jalr x5, 20(x1)
    tbl.push_back(entry_t'{32'h3050_91F3, 32'h308, 1'b0, 32'h0, 32'h0,
                           32'h305, 32'h0, 32'h0000_060D, C_CSR, 1'b0}); // csrrw
    tbl.push_back(entry_t'{32'hFFFF_FFFF, 32'h500, 1'b0, 32'h0, 32'h0,
                           32'h0, 32'h0, 32'h0000_0500, C_NONE, 1'b0}); // illegal opcode
    tbl.push_back(entry_t'{32'h0420_8BE3, 32'h400, 1'b1, 32'h0, 32'h0,
                           32'h856, 32'h0, 32'h0000_0C56, C_BR, 1'b1}); // beq +0x856
    add_branch(BR_BEQ, 32'h1234_5678, 32'h1234_5678, 1'b1);
    add_branch(BR_BEQ, 32'h5, 32'h6, 1'b0);
    add_branch(BR_BNE, 32'h5, 32'h6, 1'b1);
    add_branch(BR_BNE, 32'h7, 32'h7, 1'b0);
    add_branch(BR_BLT, 32'hFFFF_FFFF, 32'h1, 1'b1);
    add_branch(BR_BLT, 32'h1, 32'hFFFF_FFFF, 1'b0);
    add_branch(BR_BGE, 32'h1, 32'hFFFF_FFFF, 1'b1);
    add_branch(BR_BGE, 32'hFFFF_FFFF, 32'h1, 1'b0);
    add_branch(BR_BLTU, 32'h1, 32'hFFFF_FFFF, 1'b1);
    add_branch(BR_BLTU, 32'hFFFF_FFFF, 32'h1, 1'b0);
    add_branch(BR_BGEU, 32'hFFFF_FFFF, 32'h1, 1'b1);
    add_branch(BR_BGEU, 32'h1, 32'hFFFF_FFFF, 1'b0);
    foreach (tbl[k]) begin
      apply_entry(tbl[k]);
    end

    write_reg(5'd1, 32'h55);
    write_reg(5'd2, 32'h55); // beq below is taken
    redirect_then_check(I_JAL, I_ADD, C_ALU);
    redirect_then_check(I_BEQ, I_SW, C_STORE);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/main_control.sv
hdl/branch_compare.sv
hdl/hazard_unit.sv
hdl/id_stage.sv
dv/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ns -j 0 -f vlog.f \
    --top-module tb_id_stage -o sim_tb_id_stage; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_id_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
